// ==== flist.f ====
+incdir+design
design/keyer_pkg.sv
design/video_timing.sv
design/chroma_key.sv
design/centroid_tracker.sv
design/video_mux.sv
design/keyer_top.sv
bench/keyer_tb.sv

// ==== Bender.yml ====
package:
  name: keyer

sources:
  - include_dirs:
      - design
    files:
      - design/keyer_pkg.sv
      - design/video_timing.sv
      - design/chroma_key.sv
      - design/centroid_tracker.sv
      - design/video_mux.sv
      - design/keyer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/keyer_tb.sv

// ==== bench/keyer_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "keyer_defines.svh"

module keyer_tb;

  // ==============================
  // small raster and constants
  // ==============================

  localparam int H_ACTIVE     = 32;
  localparam int H_FRONT      = 4;
  localparam int H_SYNC       = 4;
  localparam int H_BACK       = 4;
  localparam int V_ACTIVE     = 24;
  localparam int V_FRONT      = 2;
  localparam int V_SYNC       = 2;
  localparam int V_BACK       = 2;
  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  // chroma pipe plus the mux register
  localparam int OUT_LATENCY  = `KEYER_KEY_LATENCY + 1;
  localparam int NUM_ROWS     = 10;

  // pixel source kinds
  localparam logic [1:0] SRC_LFSR  = 2'd0;
  localparam logic [1:0] SRC_SOLID = 2'd1;
  localparam logic [1:0] SRC_RECT  = 2'd2;

  // pure green sits inside KEY_BOUNDS, pure red well outside
  localparam keyer_pkg::rgb565_t     KEY_565    = 16'h07E0;
  localparam keyer_pkg::rgb565_t     PLAYER_565 = 16'hF800;
  localparam keyer_pkg::key_bounds_t KEY_BOUNDS = {8'd20, 8'd50, 8'd40, 8'd70};
  localparam keyer_pkg::key_bounds_t MID_BOUNDS = {8'h60, 8'hA0, 8'h50, 8'hB0};
  localparam keyer_pkg::key_bounds_t NARROW_BOUNDS = {8'h70, 8'h90, 8'h40, 8'hC0};

  // player rectangle, inclusive corners
  localparam int RECT_X0 = 5;
  localparam int RECT_X1 = 12;
  localparam int RECT_Y0 = 3;
  localparam int RECT_Y1 = 10;

  // where the source marks its last pixel too soon
  localparam int EARLY_H = 10;
  localparam int EARLY_V = 12;

  typedef struct packed {
    keyer_pkg::disp_mode_e  mode;
    logic                   xhair;
    keyer_pkg::key_bounds_t bounds;
    logic [1:0]             src;
    logic [3:0]             gap;
    logic                   early;
    logic [3:0]             frames;
  } test_row_t;

  typedef struct packed {
    logic            hsync;
    logic            vsync;
    logic            de;
    keyer_pkg::rgb_t rgb;
  } video_out_t;

  // ==============================
  // DUT and clock
  // ==============================

  logic                   clk_pixel;
  logic                   recent_reset;
  keyer_pkg::rgb565_t     pix_data;
  logic                   pix_valid;
  logic                   pix_last;
  logic                   pix_ready;
  keyer_pkg::key_bounds_t bounds;
  keyer_pkg::disp_mode_e  mode;
  logic                   crosshair_en;
  keyer_pkg::rgb_t        rgb;
  logic                   hsync;
  logic                   vsync;
  logic                   de;

  keyer_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) dut_i (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .pix_data_i     (pix_data),
    .pix_valid_i    (pix_valid),
    .pix_last_i     (pix_last),
    .pix_ready_o    (pix_ready),
    .bounds_i       (bounds),
    .mode_i         (mode),
    .crosshair_en_i (crosshair_en),
    .rgb_o          (rgb),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .de_o           (de)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel;
  end

  // ==============================
  // model state
  // ==============================

  test_row_t          rows [NUM_ROWS];
  video_out_t         exp_q [$];
  logic [31:0]        lfsr_state;
  int                 sum_x;
  int                 sum_y;
  int                 n_player;
  int                 cent_x;
  int                 cent_y;
  logic               holding;
  int                 cycle_count;
  int                 cycle_limit;

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[14:0], fb};
    end
    return val;
  endfunction

  // 5:6:5 scaled up, low bits left at zero
  function automatic keyer_pkg::rgb_t expand_565(input keyer_pkg::rgb565_t p);
    keyer_pkg::rgb_t c;
    c.red   = 8'(int'(p[15:11]) * 8);
    c.green = 8'(int'(p[10:5]) * 4);
    c.blue  = 8'(int'(p[4:0]) * 8);
    return c;
  endfunction

  function automatic logic [7:0] luma_of(input keyer_pkg::rgb_t c);
    int y;
    y = ((66 * int'(c.red) + 129 * int'(c.green) + 25 * int'(c.blue)) >>> 8) + 16;
    return 8'(y);
  endfunction

  // backdrop needs both chroma values inside their inclusive windows
  function automatic logic is_player(input keyer_pkg::rgb_t c,
                                     input keyer_pkg::key_bounds_t kb);
    int cr;
    int cb;
    cr = (((112 * int'(c.red) - 94 * int'(c.green) - 18 * int'(c.blue)) >>> 8) + 128) & 255;
    cb = (((112 * int'(c.blue) - 38 * int'(c.red) - 74 * int'(c.green)) >>> 8) + 128) & 255;
    return !((cr >= kb.cr_lo) && (cr <= kb.cr_hi) && (cb >= kb.cb_lo) && (cb <= kb.cb_hi));
  endfunction

  function automatic video_out_t predict_out(input int h, input int v,
                                             input keyer_pkg::rgb_t c, input logic [7:0] luma,
                                             input logic player, input test_row_t row);
    video_out_t o;
    o.hsync = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
    o.vsync = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
    o.de    = (h < H_ACTIVE) && (v < V_ACTIVE);
    if (!o.de) begin
      o.rgb = '0;
    end else if (row.xhair && ((h == cent_x) || (v == cent_y))) begin
      o.rgb = `KEYER_CROSSHAIR_RGB;
    end else begin
      case (row.mode)
        keyer_pkg::MODE_CAMERA: o.rgb = c;
        keyer_pkg::MODE_LUMA:   o.rgb = {luma, luma, luma};
        keyer_pkg::MODE_MASK:   o.rgb = player ? 24'hFFFFFF : 24'h000000;
        default:                o.rgb = player ? c : `KEYER_BACKDROP_RGB;
      endcase
    end
    return o;
  endfunction

  function automatic keyer_pkg::rgb565_t source_pixel(input int h, input int v,
                                                      input logic [1:0] src);
    if (src == SRC_LFSR) begin
      return lfsr_bits(16);
    end else if ((src == SRC_RECT) && (h >= RECT_X0) && (h <= RECT_X1)
                 && (v >= RECT_Y0) && (v <= RECT_Y1)) begin
      return PLAYER_565;
    end
    return KEY_565;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h at cycle %0d", name, got, want, cycle_count);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ==============================
  // stimulus table
  // ==============================

  task automatic load_rows();
    int total;
    rows[0] = '{keyer_pkg::MODE_CAMERA, 1'b0, KEY_BOUNDS, SRC_LFSR, 4'd0, 1'b0, 4'd1};
    // every third position missing, fill shows instead
    rows[1] = '{keyer_pkg::MODE_CAMERA, 1'b0, KEY_BOUNDS, SRC_LFSR, 4'd3, 1'b0, 4'd1};
    rows[2] = '{keyer_pkg::MODE_LUMA, 1'b0, KEY_BOUNDS, SRC_LFSR, 4'd0, 1'b0, 4'd1};
    rows[3] = '{keyer_pkg::MODE_MASK, 1'b0, MID_BOUNDS, SRC_LFSR, 4'd0, 1'b0, 4'd1};
    rows[4] = '{keyer_pkg::MODE_MASK, 1'b0, NARROW_BOUNDS, SRC_LFSR, 4'd5, 1'b0, 4'd1};
    rows[5] = '{keyer_pkg::MODE_KEYED, 1'b0, MID_BOUNDS, SRC_LFSR, 4'd0, 1'b0, 4'd1};
    // rectangle in frame N sets the crosshair of frame N+1
    rows[6] = '{keyer_pkg::MODE_KEYED, 1'b1, KEY_BOUNDS, SRC_RECT, 4'd0, 1'b0, 4'd2};
    // empty first frame, the second one still shows the old lines
    rows[7] = '{keyer_pkg::MODE_KEYED, 1'b1, KEY_BOUNDS, SRC_SOLID, 4'd0, 1'b0, 4'd2};
    rows[8] = '{keyer_pkg::MODE_CAMERA, 1'b0, KEY_BOUNDS, SRC_RECT, 4'd0, 1'b0, 4'd1};
    // early end of frame, then a normal frame from 0,0
    rows[9] = '{keyer_pkg::MODE_CAMERA, 1'b0, KEY_BOUNDS, SRC_LFSR, 4'd0, 1'b1, 4'd2};
    total = 0;
    foreach (rows[r]) begin
      total += rows[r].frames;
    end
    // reset, drain and some slack on top of the frames
    cycle_limit = total * FRAME_CYCLES + 2 + OUT_LATENCY + 64;
  endtask

  // ==============================
  // one pixel period
  // ==============================

  task automatic drive_source(input int h, input int v, input test_row_t row,
                              input logic early_frame, input logic active);
    logic gap_hit;
    gap_hit = (row.gap != 0) && (((h + 7 * v) % row.gap) == 1);
    // a marked pixel stays on the bus until it is taken
    if (!holding) begin
      pix_valid = 1'b0;
      pix_last  = 1'b0;
      pix_data  = '0;
      if (active && !gap_hit) begin
        pix_valid = 1'b1;
        pix_data  = source_pixel(h, v, row.src);
        if (early_frame && (h == EARLY_H) && (v == EARLY_V)) begin
          pix_last = 1'b1;
          holding  = 1'b1;
        end else if ((h == H_ACTIVE - 1) && (v == V_ACTIVE - 1)) begin
          pix_last = 1'b1;
        end
      end
    end
  endtask

  task automatic run_cycle(input int h, input int v, input test_row_t row,
                           input logic early_frame);
    video_out_t         want;
    keyer_pkg::rgb_t    c;
    keyer_pkg::rgb565_t pix;
    logic [7:0]         luma;
    logic               active;
    logic               frame_end;
    logic               ready_exp;
    logic               xfer;
    logic               player;
    @(negedge clk_pixel);
    // outputs belong to the position OUT_LATENCY cycles back
    want = exp_q.pop_front();
    check_value("hsync_o", hsync, want.hsync);
    check_value("vsync_o", vsync, want.vsync);
    check_value("de_o", de, want.de);
    check_value("rgb_o", rgb, want.rgb);
    // settings only change at the top of a frame
    if ((h == 0) && (v == 0)) begin
      mode         = row.mode;
      crosshair_en = row.xhair;
      bounds       = row.bounds;
    end
    active    = (h < H_ACTIVE) && (v < V_ACTIVE);
    frame_end = (h == H_ACTIVE - 1) && (v == V_ACTIVE - 1);
    drive_source(h, v, row, early_frame, active);
    #1;
    ready_exp = active && !(pix_last && !frame_end);
    check_value("pix_ready_o", pix_ready, ready_exp);
    xfer = pix_valid && ready_exp;
    if (xfer) begin
      holding = 1'b0;
    end
    pix    = xfer ? pix_data : `KEYER_FILL_RGB565;
    c      = expand_565(pix);
    luma   = luma_of(c);
    player = is_player(c, row.bounds);
    exp_q.push_back(predict_out(h, v, c, luma, player, row));
    // centroid of this frame takes effect from the next frame on
    if (active && player) begin
      sum_x    += h;
      sum_y    += v;
      n_player += 1;
    end
    if (frame_end) begin
      if (n_player > 0) begin
        cent_x = sum_x / n_player;
        cent_y = sum_y / n_player;
      end
      sum_x    = 0;
      sum_y    = 0;
      n_player = 0;
    end
  endtask

  // ==============================
  // run limit
  // ==============================

  initial begin
    cycle_count = 0;
  end

  always @(posedge clk_pixel) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run did not finish within %0d clock cycles", cycle_limit);
      $display("Something failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ==============================
  // main sequence
  // ==============================

  initial begin
    video_out_t idle;
    recent_reset = 1'b1;
    pix_data     = '0;
    pix_valid    = 1'b0;
    pix_last     = 1'b0;
    bounds       = KEY_BOUNDS;
    mode         = keyer_pkg::MODE_CAMERA;
    crosshair_en = 1'b0;
    lfsr_state   = 32'h4840_d260;
    holding      = 1'b0;
    sum_x        = 0;
    sum_y        = 0;
    n_player     = 0;
    cent_x       = 0;
    cent_y       = 0;
    load_rows();
    // outputs quiet while reset is held
    repeat (2) begin
      @(negedge clk_pixel);
      check_value("de_o", de, 0);
      check_value("hsync_o", hsync, 0);
      check_value("vsync_o", vsync, 0);
      check_value("pix_ready_o", pix_ready, 0);
      check_value("rgb_o", rgb, 0);
    end
    recent_reset = 1'b0;
    // pipeline still holds reset values for the first cycles
    idle = '0;
    repeat (OUT_LATENCY) begin
      exp_q.push_back(idle);
    end
    foreach (rows[r]) begin
      for (int f = 0; f < rows[r].frames; f++) begin
        for (int v = 0; v < V_TOTAL; v++) begin
          for (int h = 0; h < H_TOTAL; h++) begin
            run_cycle(h, v, rows[r], rows[r].early && (f == 0));
          end
        end
      end
    end
    // flush the tail of the last frame
    for (int h = 0; h < OUT_LATENCY; h++) begin
      run_cycle(h, 0, rows[NUM_ROWS-1], 1'b0);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/keyer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "keyer_defines.svh"

module keyer_top #(
  parameter int H_ACTIVE = `KEYER_H_ACTIVE,
  parameter int H_FRONT  = `KEYER_H_FRONT,
  parameter int H_SYNC   = `KEYER_H_SYNC,
  parameter int H_BACK   = `KEYER_H_BACK,
  parameter int V_ACTIVE = `KEYER_V_ACTIVE,
  parameter int V_FRONT  = `KEYER_V_FRONT,
  parameter int V_SYNC   = `KEYER_V_SYNC,
  parameter int V_BACK   = `KEYER_V_BACK
) (
  input  wire                           clk_pixel,
  input  wire                           recent_reset,
  // pixel stream in
  input  wire keyer_pkg::rgb565_t       pix_data_i,
  input  wire                           pix_valid_i,
  input  wire                           pix_last_i,
  output logic                          pix_ready_o,
  // keying controls
  input  wire keyer_pkg::key_bounds_t   bounds_i,
  input  wire keyer_pkg::disp_mode_e    mode_i,
  input  wire                           crosshair_en_i,
  // video out
  output keyer_pkg::rgb_t               rgb_o,
  output logic                          hsync_o,
  output logic                          vsync_o,
  output logic                          de_o
);

  keyer_pkg::raster_t       raster;
  keyer_pkg::raster_t       raster_dly [`KEYER_KEY_LATENCY];
  keyer_pkg::rgb565_t       pix_sel;
  keyer_pkg::keyed_pixel_t  keyed;
  keyer_pkg::centroid_t     centroid;

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) timing_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .raster_o     (raster)
  );

  // ==============================
  // stream ready and fill
  // ==============================

  // only pull pixels inside the active area; a pixel marked last is
  // held off until the raster reaches the last active position
  assign pix_ready_o = raster.active && !(pix_last_i && !raster.frame_end);

  // no transfer this cycle means the fill color goes down the pipe
  assign pix_sel = (pix_valid_i && pix_ready_o) ? pix_data_i : `KEYER_FILL_RGB565;

  chroma_key key_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pixel_i      (pix_sel),
    .bounds_i     (bounds_i),
    .keyed_o      (keyed)
  );

  // raster delayed to line up with the keyed pixel
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      for (int i = 0; i < `KEYER_KEY_LATENCY; i++) begin
        raster_dly[i] <= '0;
      end
    end else begin
      raster_dly[0] <= raster;
      for (int i = 1; i < `KEYER_KEY_LATENCY; i++) begin
        raster_dly[i] <= raster_dly[i-1];
      end
    end
  end

  centroid_tracker tracker_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .raster_i     (raster_dly[`KEYER_KEY_LATENCY-1]),
    .player_i     (keyed.player),
    .centroid_o   (centroid)
  );

  video_mux mux_i (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .raster_i       (raster_dly[`KEYER_KEY_LATENCY-1]),
    .keyed_i        (keyed),
    .mode_i         (mode_i),
    .crosshair_en_i (crosshair_en_i),
    .centroid_i     (centroid),
    .rgb_o          (rgb_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .de_o           (de_o)
  );

endmodule

`default_nettype wire

// ==== design/video_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "keyer_defines.svh"

module video_mux (
  input  wire                           clk_pixel,
  input  wire                           recent_reset,
  input  wire keyer_pkg::raster_t       raster_i,
  input  wire keyer_pkg::keyed_pixel_t  keyed_i,
  input  wire keyer_pkg::disp_mode_e    mode_i,
  input  wire                           crosshair_en_i,
  input  wire keyer_pkg::centroid_t     centroid_i,
  output keyer_pkg::rgb_t               rgb_o,
  output logic                          hsync_o,
  output logic                          vsync_o,
  output logic                          de_o
);

  keyer_pkg::rgb_t bg_pix;
  keyer_pkg::rgb_t out_pix;
  logic            on_cross;

  // ==============================
  // background by display mode
  // ==============================

  always_comb begin
    case (mode_i)
      keyer_pkg::MODE_CAMERA: begin
        bg_pix = keyed_i.pixel;
      end
      keyer_pkg::MODE_LUMA: begin
        // grayscale, luma on every channel
        bg_pix = {keyed_i.luma, keyed_i.luma, keyed_i.luma};
      end
      keyer_pkg::MODE_MASK: begin
        bg_pix = keyed_i.player ? 24'hFFFFFF : 24'h000000;
      end
      default: begin
        // player over the flat backdrop
        bg_pix = keyed_i.player ? keyed_i.pixel : keyer_pkg::rgb_t'(`KEYER_BACKDROP_RGB);
      end
    endcase
  end

  // crosshair: full row and full column through the centroid
  assign on_cross = crosshair_en_i
                  && ((raster_i.hcount == centroid_i.x) || (raster_i.vcount == centroid_i.y));

  always_comb begin
    if (!raster_i.active) begin
      out_pix = '0;
    end else if (on_cross) begin
      out_pix = keyer_pkg::rgb_t'(`KEYER_CROSSHAIR_RGB);
    end else begin
      out_pix = bg_pix;
    end
  end

  // pixel and syncs leave together in one register stage
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      rgb_o   <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
    end else begin
      rgb_o   <= out_pix;
      hsync_o <= raster_i.hsync;
      vsync_o <= raster_i.vsync;
      de_o    <= raster_i.active;
    end
  end

endmodule

`default_nettype wire

// ==== design/centroid_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "keyer_defines.svh"

module centroid_tracker (
  input  wire                       clk_pixel,
  input  wire                       recent_reset,
  input  wire keyer_pkg::raster_t   raster_i,
  input  wire                       player_i,
  output keyer_pkg::centroid_t      centroid_o
);

  // sums of a full 720p frame need 32 bits, the count 21
  localparam int CNT_W     = `KEYER_HCOUNT_W + `KEYER_VCOUNT_W;
  localparam int SUM_W     = CNT_W + `KEYER_HCOUNT_W;
  // the mean is a coordinate, so a short quotient is enough
  localparam int DIV_STEPS = `KEYER_HCOUNT_W + 1;
  localparam int STEP_W    = $clog2(DIV_STEPS);
  localparam int REM_W     = CNT_W + DIV_STEPS;

  // ==============================
  // per frame accumulation
  // ==============================

  logic [SUM_W-1:0] acc_x;
  logic [SUM_W-1:0] acc_y;
  logic [CNT_W-1:0] acc_n;
  logic             hit;
  logic [SUM_W-1:0] acc_x_next;
  logic [SUM_W-1:0] acc_y_next;
  logic [CNT_W-1:0] acc_n_next;

  // the frame_end pixel itself still counts
  always_comb begin
    hit        = raster_i.active && player_i;
    acc_x_next = acc_x + (hit ? SUM_W'(raster_i.hcount) : '0);
    acc_y_next = acc_y + (hit ? SUM_W'(raster_i.vcount) : '0);
    acc_n_next = acc_n + CNT_W'(hit);
  end

  // ==============================
  // restoring divider
  // ==============================

  keyer_pkg::div_state_e state;
  logic [STEP_W-1:0]     step;
  logic [SUM_W-1:0]      sum_y_lat;
  logic [CNT_W-1:0]      div_n;
  logic [REM_W-1:0]      rem;
  logic [DIV_STEPS-1:0]  quo;
  logic [REM_W-1:0]      shifted_div;
  logic                  take;
  logic [REM_W-1:0]      rem_next;
  logic [DIV_STEPS-1:0]  quo_next;
  keyer_pkg::hcount_t    cx;
  keyer_pkg::vcount_t    cy;

  // one quotient bit per cycle, msb first
  always_comb begin
    shifted_div = REM_W'(div_n) << step;
    take        = rem >= shifted_div;
    rem_next    = take ? (rem - shifted_div) : rem;
    quo_next    = quo;
    if (take) begin
      quo_next[step] = 1'b1;
    end
  end

  // control: accumulators, state, step, published centroid
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      acc_x      <= '0;
      acc_y      <= '0;
      acc_n      <= '0;
      state      <= keyer_pkg::DIV_IDLE;
      step       <= '0;
      centroid_o <= '0;
    end else begin
      if (raster_i.frame_end) begin
        acc_x <= '0;
        acc_y <= '0;
        acc_n <= '0;
      end else begin
        acc_x <= acc_x_next;
        acc_y <= acc_y_next;
        acc_n <= acc_n_next;
      end

      case (state)
        keyer_pkg::DIV_IDLE: begin
          // an empty frame keeps the old centroid
          if (raster_i.frame_end && (acc_n_next != '0)) begin
            state <= keyer_pkg::DIV_X;
            step  <= STEP_W'(DIV_STEPS - 1);
          end
        end
        keyer_pkg::DIV_X: begin
          if (step == '0) begin
            state <= keyer_pkg::DIV_Y;
            step  <= STEP_W'(DIV_STEPS - 1);
          end else begin
            step <= step - 1'b1;
          end
        end
        keyer_pkg::DIV_Y: begin
          if (step == '0) begin
            state <= keyer_pkg::DIV_DONE;
          end else begin
            step <= step - 1'b1;
          end
        end
        default: begin
          centroid_o.x <= cx;
          centroid_o.y <= cy;
          state        <= keyer_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  // datapath: latched sums, remainder and quotient
  always_ff @(posedge clk_pixel) begin
    case (state)
      keyer_pkg::DIV_IDLE: begin
        rem       <= REM_W'(acc_x_next);
        sum_y_lat <= acc_y_next;
        div_n     <= acc_n_next;
        quo       <= '0;
      end
      keyer_pkg::DIV_X: begin
        if (step == '0) begin
          cx  <= quo_next[`KEYER_HCOUNT_W-1:0];
          rem <= REM_W'(sum_y_lat);
          quo <= '0;
        end else begin
          rem <= rem_next;
          quo <= quo_next;
        end
      end
      keyer_pkg::DIV_Y: begin
        rem <= rem_next;
        quo <= quo_next;
        if (step == '0) begin
          cy <= quo_next[`KEYER_VCOUNT_W-1:0];
        end
      end
      default: begin
        quo <= '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/chroma_key.sv ====
`timescale 1ns/1ns
`default_nettype none

module chroma_key (
  input  wire                           clk_pixel,
  input  wire                           recent_reset,
  input  wire keyer_pkg::rgb565_t       pixel_i,
  input  wire keyer_pkg::key_bounds_t   bounds_i,
  output keyer_pkg::keyed_pixel_t       keyed_o
);

  // ==============================
  // stage 1: 565 to 888
  // ==============================

  keyer_pkg::rgb_t s1_rgb;

  // low bits zero filled, no replication of the msbs
  always_ff @(posedge clk_pixel) begin
    s1_rgb.red   <= {pixel_i[15:11], 3'b000};
    s1_rgb.green <= {pixel_i[10:5], 2'b00};
    s1_rgb.blue  <= {pixel_i[4:0], 3'b000};
  end

  // ==============================
  // stage 2: rgb to YCrCb
  // ==============================

  // channels widened to signed so the chroma sums can go negative
  logic signed [16:0] r_s;
  logic signed [16:0] g_s;
  logic signed [16:0] b_s;
  logic        [16:0] y_sum;
  logic signed [16:0] cr_sum;
  logic signed [16:0] cb_sum;

  always_comb begin
    r_s = $signed({9'd0, s1_rgb.red});
    g_s = $signed({9'd0, s1_rgb.green});
    b_s = $signed({9'd0, s1_rgb.blue});
    // luma sum peaks near 56k, fits unsigned
    y_sum = (17'd66 * {9'd0, s1_rgb.red}) + (17'd129 * {9'd0, s1_rgb.green})
          + (17'd25 * {9'd0, s1_rgb.blue});
    // chroma sums stay within +-28560
    cr_sum = (17'sd112 * r_s) - (17'sd94 * g_s) - (17'sd18 * b_s);
    cb_sum = (17'sd112 * b_s) - (17'sd38 * r_s) - (17'sd74 * g_s);
  end

  keyer_pkg::rgb_t  s2_rgb;
  keyer_pkg::chan_t s2_y;
  keyer_pkg::chan_t s2_cr;
  keyer_pkg::chan_t s2_cb;

  always_ff @(posedge clk_pixel) begin
    s2_rgb <= s1_rgb;
    s2_y   <= y_sum[15:8] + 8'd16;
    // bits 15:8 are the low byte of the floor shift by 8,
    // adding 128 to that byte just flips its msb
    s2_cr  <= {~cr_sum[15], cr_sum[14:8]};
    s2_cb  <= {~cb_sum[15], cb_sum[14:8]};
  end

  // ==============================
  // stage 3: window test
  // ==============================

  logic cr_in_win;
  logic cb_in_win;

  // both windows inclusive at either end
  assign cr_in_win = (s2_cr >= bounds_i.cr_lo) && (s2_cr <= bounds_i.cr_hi);
  assign cb_in_win = (s2_cb >= bounds_i.cb_lo) && (s2_cb <= bounds_i.cb_hi);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      keyed_o <= '0;
    end else begin
      keyed_o.pixel  <= s2_rgb;
      keyed_o.luma   <= s2_y;
      // backdrop only when both chroma channels sit in their window
      keyed_o.player <= !(cr_in_win && cb_in_win);
    end
  end

endmodule

`default_nettype wire

// ==== design/video_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "keyer_defines.svh"

module video_timing #(
  parameter int H_ACTIVE = `KEYER_H_ACTIVE,
  parameter int H_FRONT  = `KEYER_H_FRONT,
  parameter int H_SYNC   = `KEYER_H_SYNC,
  parameter int H_BACK   = `KEYER_H_BACK,
  parameter int V_ACTIVE = `KEYER_V_ACTIVE,
  parameter int V_FRONT  = `KEYER_V_FRONT,
  parameter int V_SYNC   = `KEYER_V_SYNC,
  parameter int V_BACK   = `KEYER_V_BACK
) (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  output keyer_pkg::raster_t  raster_o
);

  // totals and decode points, sized to the counters
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam keyer_pkg::hcount_t H_LAST     = keyer_pkg::hcount_t'(H_TOTAL - 1);
  localparam keyer_pkg::hcount_t H_ACT_LAST = keyer_pkg::hcount_t'(H_ACTIVE - 1);
  localparam keyer_pkg::hcount_t HS_START   = keyer_pkg::hcount_t'(H_ACTIVE + H_FRONT);
  localparam keyer_pkg::hcount_t HS_END     = keyer_pkg::hcount_t'(H_ACTIVE + H_FRONT + H_SYNC);

  localparam keyer_pkg::vcount_t V_LAST     = keyer_pkg::vcount_t'(V_TOTAL - 1);
  localparam keyer_pkg::vcount_t V_ACT_LAST = keyer_pkg::vcount_t'(V_ACTIVE - 1);
  localparam keyer_pkg::vcount_t VS_START   = keyer_pkg::vcount_t'(V_ACTIVE + V_FRONT);
  localparam keyer_pkg::vcount_t VS_END     = keyer_pkg::vcount_t'(V_ACTIVE + V_FRONT + V_SYNC);

  // free running scan position
  keyer_pkg::hcount_t h_cnt;
  keyer_pkg::vcount_t v_cnt;

  // raster_o is the registered decode of the counters, so after reset
  // it steps through 0,0 then 1,0 and so on, one position per cycle
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      h_cnt    <= '0;
      v_cnt    <= '0;
      raster_o <= '0;
    end else begin
      raster_o.hcount    <= h_cnt;
      raster_o.vcount    <= v_cnt;
      raster_o.active    <= (h_cnt <= H_ACT_LAST) && (v_cnt <= V_ACT_LAST);
      raster_o.hsync     <= (h_cnt >= HS_START) && (h_cnt < HS_END);
      raster_o.vsync     <= (v_cnt >= VS_START) && (v_cnt < VS_END);
      raster_o.frame_end <= (h_cnt == H_ACT_LAST) && (v_cnt == V_ACT_LAST);

      // wrap the pixel count at the line end, the line count at the frame end
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        if (v_cnt == V_LAST) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/keyer_pkg.sv ====
`default_nettype none

`include "keyer_defines.svh"

package keyer_pkg;

  // raster positions
  typedef logic [`KEYER_HCOUNT_W-1:0] hcount_t;
  typedef logic [`KEYER_VCOUNT_W-1:0] vcount_t;

  // 5:6:5 pixel as it arrives from the stream
  typedef logic [15:0] rgb565_t;
  // one color or chroma channel
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

  // frame_end marks the last active pixel of a frame
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    vsync;
    logic    active;
    logic    frame_end;
  } raster_t;

  // inclusive Cr/Cb window that counts as backdrop
  typedef struct packed {
    chan_t cr_lo;
    chan_t cr_hi;
    chan_t cb_lo;
    chan_t cb_hi;
  } key_bounds_t;

  typedef struct packed {
    rgb_t  pixel;
    chan_t luma;
    logic  player;
  } keyed_pixel_t;

  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } centroid_t;

  typedef enum logic [1:0] {
    MODE_CAMERA = 2'd0,
    MODE_LUMA   = 2'd1,
    MODE_MASK   = 2'd2,
    MODE_KEYED  = 2'd3
  } disp_mode_e;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_X    = 2'd1,
    DIV_Y    = 2'd2,
    DIV_DONE = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

// ==== design/keyer_defines.svh ====
`ifndef KEYER_DEFINES_SVH
`define KEYER_DEFINES_SVH

// ==============================
// raster timing
// ==============================

// 720p60 horizontal timing in pixel periods
`define KEYER_H_ACTIVE 1280
`define KEYER_H_FRONT 110
`define KEYER_H_SYNC 40
`define KEYER_H_BACK 220

// vertical timing in lines
`define KEYER_V_ACTIVE 720
`define KEYER_V_FRONT 5
`define KEYER_V_SYNC 5
`define KEYER_V_BACK 20

// counter widths, wide enough for the full totals
`define KEYER_HCOUNT_W 11
`define KEYER_VCOUNT_W 10

// ==============================
// colors and pipeline depth
// ==============================

// shown in place of a pixel the stream did not deliver
`define KEYER_FILL_RGB565 16'h2277
// backdrop drawn behind the player in keyed mode
`define KEYER_BACKDROP_RGB 24'h1E3C78
`define KEYER_CROSSHAIR_RGB 24'hFF0080
// pixel in to keyed pixel out of the chroma stage
`define KEYER_KEY_LATENCY 3

`endif
